// ==== src/flow_cfg_pkg.sv ====
/* flow crossbar configuration */

package flow_cfg_pkg;

  // upper limit for both the push and the pop flow count
  localparam int max_flows = 8;

  // one id addresses any flow up to the limit
  localparam int flow_id_w = $clog2(max_flows);

  // beat payload width, fixed for every build of the crossbar
  localparam int flow_data_w = 16;

  // flow counts used when the top level is not overridden
  localparam int default_num_push = 4;
  localparam int default_num_pop = 4;

endpackage

// ==== src/flow_types_pkg.sv ====
/* flow crossbar shared types */

package flow_types_pkg;

  // source or destination flow id
  typedef logic [flow_cfg_pkg::flow_id_w-1:0] flow_id_t;

  // beat payload
  typedef logic [flow_cfg_pkg::flow_data_w-1:0] flow_data_t;

  // a push beat carries its payload and the pop flow it is routed to
  typedef struct packed {
    flow_data_t data;
    flow_id_t   dest;
  } flow_beat_t;

endpackage

// ==== src/flow_demux.sv ====
/* flow crossbar push demux */

`timescale 1ns/1ps

module flow_demux #(
  parameter int num_pop = flow_cfg_pkg::default_num_pop,
  parameter bit register_demux_outputs = 1'b0
) (
  input  logic                                     clk,
  input  logic                                     reset,
  input  logic                                     push_valid,
  output logic                                     push_ready,
  input  flow_types_pkg::flow_beat_t               push_beat,
  output logic [num_pop-1:0]                       lane_valid,
  input  logic [num_pop-1:0]                       lane_ready,
  output flow_types_pkg::flow_data_t [num_pop-1:0] lane_data
);

  import flow_types_pkg::*;

  // one-hot lane select decoded from the destination id
  logic [num_pop-1:0] sel;

  always_comb begin
    for (int j = 0; j < num_pop; j++) begin
      sel[j] = (push_beat.dest == flow_id_t'(j));
    end
  end

  if (register_demux_outputs) begin : gen_reg
    logic               slot_valid;
    logic [num_pop-1:0] slot_sel;
    flow_data_t         slot_data;
    logic               slot_free;

    assign lane_valid = slot_sel & {num_pop{slot_valid}};

    always_comb begin
      for (int j = 0; j < num_pop; j++) begin
        lane_data[j] = slot_data;
      end
    end

    // slot takes a new beat when empty or draining in the same cycle
    assign slot_free = !slot_valid || (|(lane_valid & lane_ready));
    assign push_ready = slot_free;

    always_ff @(posedge clk) begin
      if (reset) begin
        slot_valid <= 1'b0;
      end else if (slot_free) begin
        slot_valid <= push_valid;
      end
    end

    always_ff @(posedge clk) begin
      if (slot_free && push_valid) begin
        slot_sel  <= sel;
        slot_data <= push_beat.data;
      end
    end
  end else begin : gen_comb
    assign lane_valid = sel & {num_pop{push_valid}};

    always_comb begin
      for (int j = 0; j < num_pop; j++) begin
        lane_data[j] = push_beat.data;
      end
    end

    // only the addressed lane can accept the beat
    assign push_ready = |(sel & lane_ready);
  end

endmodule

// ==== src/flow_rr_arbiter.sv ====
/* round-robin arbiter */

`timescale 1ns/1ps

module flow_rr_arbiter #(
  parameter int num_push = flow_cfg_pkg::default_num_push
) (
  input  logic                clk,
  input  logic                reset,
  input  logic [num_push-1:0] request,
  input  logic                hold,
  output logic [num_push-1:0] grant
);

  import flow_types_pkg::*;

  flow_id_t            ptr;
  flow_id_t            winner;
  logic [num_push-1:0] rr_grant;
  logic [num_push-1:0] grant_q;
  logic                held_q;

  // first requester at or after the priority pointer
  always_comb begin
    int   idx;
    logic found;
    rr_grant = '0;
    found = 1'b0;
    for (int k = 0; k < num_push; k++) begin
      idx = (int'(ptr) + k) % num_push;
      if (!found && request[idx]) begin
        rr_grant[idx] = 1'b1;
        found = 1'b1;
      end
    end
  end

  // a stalled grant from the last cycle is kept until it moves
  assign grant = held_q ? grant_q : rr_grant;

  always_comb begin
    winner = '0;
    for (int k = 0; k < num_push; k++) begin
      if (grant[k]) begin
        winner = flow_id_t'(k);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr     <= '0;
      grant_q <= '0;
      held_q  <= 1'b0;
    end else begin
      held_q  <= hold && (|grant);
      grant_q <= grant;
      // granted and not held means the beat transferred
      if ((|grant) && !hold) begin
        ptr <= (winner == flow_id_t'(num_push - 1)) ? '0 : winner + 1'b1;
      end
    end
  end

endmodule

// ==== src/flow_mux.sv ====
/* flow crossbar pop mux */

`timescale 1ns/1ps

module flow_mux #(
  parameter int num_push = flow_cfg_pkg::default_num_push,
  parameter bit register_pop_outputs = 1'b0
) (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic [num_push-1:0]                       lane_valid,
  output logic [num_push-1:0]                       lane_ready,
  input  flow_types_pkg::flow_data_t [num_push-1:0] lane_data,
  output logic                                      pop_valid,
  input  logic                                      pop_ready,
  output flow_types_pkg::flow_data_t                pop_data
);

  import flow_types_pkg::*;

  logic [num_push-1:0] grant;
  logic                arb_hold;
  logic                sel_valid;
  flow_data_t          sel_data;
  // downstream stage can take the selected beat this cycle
  logic                accept;

  flow_rr_arbiter #(
    .num_push(num_push)
  ) i_arbiter (
    .clk    (clk),
    .reset  (reset),
    .request(lane_valid),
    .hold   (arb_hold),
    .grant  (grant)
  );

  assign sel_valid = |(grant & lane_valid);

  always_comb begin
    sel_data = '0;
    for (int k = 0; k < num_push; k++) begin
      if (grant[k]) begin
        sel_data = lane_data[k];
      end
    end
  end

  assign lane_ready = grant & {num_push{accept}};

  // keep the grant while the selected beat cannot move
  assign arb_hold = sel_valid && !accept;

  if (register_pop_outputs) begin : gen_reg
    logic       slot_valid;
    flow_data_t slot_data;

    assign accept = !slot_valid || pop_ready;
    assign pop_valid = slot_valid;
    assign pop_data = slot_data;

    always_ff @(posedge clk) begin
      if (reset) begin
        slot_valid <= 1'b0;
      end else if (accept) begin
        slot_valid <= sel_valid;
      end
    end

    always_ff @(posedge clk) begin
      if (accept && sel_valid) begin
        slot_data <= sel_data;
      end
    end
  end else begin : gen_comb
    assign accept = pop_ready;
    assign pop_valid = sel_valid;
    assign pop_data = sel_data;
  end

endmodule

// ==== src/flow_xbar.sv ====
/* flow crossbar top */

`timescale 1ns/1ps

module flow_xbar #(
  parameter int num_push = flow_cfg_pkg::default_num_push,
  parameter int num_pop = flow_cfg_pkg::default_num_pop,
  parameter bit register_demux_outputs = 1'b0,
  parameter bit register_pop_outputs = 1'b0
) (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic [num_push-1:0]                       push_valid,
  output logic [num_push-1:0]                       push_ready,
  input  flow_types_pkg::flow_beat_t [num_push-1:0] push_beat,
  output logic [num_pop-1:0]                        pop_valid,
  input  logic [num_pop-1:0]                        pop_ready,
  output flow_types_pkg::flow_data_t [num_pop-1:0]  pop_data
);

  import flow_types_pkg::*;

  // lane grid indexed by push flow, then pop flow
  logic [num_push-1:0][num_pop-1:0]       push_lane_valid;
  logic [num_push-1:0][num_pop-1:0]       push_lane_ready;
  flow_data_t [num_push-1:0][num_pop-1:0] push_lane_data;

  // the same grid seen from the pop side
  logic [num_pop-1:0][num_push-1:0]       pop_lane_valid;
  logic [num_pop-1:0][num_push-1:0]       pop_lane_ready;
  flow_data_t [num_pop-1:0][num_push-1:0] pop_lane_data;

  for (genvar i = 0; i < num_push; i++) begin : gen_push
    flow_demux #(
      .num_pop               (num_pop),
      .register_demux_outputs(register_demux_outputs)
    ) i_demux (
      .clk       (clk),
      .reset     (reset),
      .push_valid(push_valid[i]),
      .push_ready(push_ready[i]),
      .push_beat (push_beat[i]),
      .lane_valid(push_lane_valid[i]),
      .lane_ready(push_lane_ready[i]),
      .lane_data (push_lane_data[i])
    );

    for (genvar j = 0; j < num_pop; j++) begin : gen_lane
      assign pop_lane_valid[j][i] = push_lane_valid[i][j];
      assign pop_lane_data[j][i] = push_lane_data[i][j];
      assign push_lane_ready[i][j] = pop_lane_ready[j][i];
    end
  end

  for (genvar j = 0; j < num_pop; j++) begin : gen_pop
    flow_mux #(
      .num_push            (num_push),
      .register_pop_outputs(register_pop_outputs)
    ) i_mux (
      .clk       (clk),
      .reset     (reset),
      .lane_valid(pop_lane_valid[j]),
      .lane_ready(pop_lane_ready[j]),
      .lane_data (pop_lane_data[j]),
      .pop_valid (pop_valid[j]),
      .pop_ready (pop_ready[j]),
      .pop_data  (pop_data[j])
    );
  end

endmodule

// ==== testbench/xbar_monitor.sv ====
/* crossbar scoreboard monitor */

`timescale 1ns/1ps

module xbar_monitor #(
  parameter int num_push = flow_cfg_pkg::default_num_push,
  parameter int num_pop = flow_cfg_pkg::default_num_pop
) (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic [num_push-1:0]                       push_valid,
  input  logic [num_push-1:0]                       push_ready,
  input  flow_types_pkg::flow_beat_t [num_push-1:0] push_beat,
  input  logic [num_pop-1:0]                        pop_valid,
  input  logic [num_pop-1:0]                        pop_ready,
  input  flow_types_pkg::flow_data_t [num_pop-1:0]  pop_data,
  input  logic                                      fair_check,
  output int                                        pending,
  output logic                                      error
);

  import flow_cfg_pkg::*;
  import flow_types_pkg::*;

  localparam int stall_limit = 32;

  // expected beats per source/destination pair, index src * num_pop + dest
  flow_data_t         sb[num_push*num_pop][$];
  logic [num_pop-1:0] last_hold;
  flow_data_t         last_data[num_pop];
  int                 stall_cnt[num_pop];
  int                 since_seen[num_push];

  task automatic report(input string msg);
    $display("FAILED t=%0t: %s", $time, msg);
    error = 1'b1;
  endtask

  always @(negedge clk) begin
    int   src;
    int   idx;
    logic waiting;
    if (reset) begin
      error = 1'b0;
      pending = 0;
      last_hold = '0;
      foreach (sb[k])
        sb[k].delete();
      foreach (stall_cnt[j])
        stall_cnt[j] = 0;
    end else begin
      // pushes are logged before pops so a zero latency path also works
      for (int i = 0; i < num_push; i++) begin
        if (push_valid[i] && push_ready[i]) begin
          sb[i * num_pop + int'(push_beat[i].dest)].push_back(push_beat[i].data);
          pending++;
        end
      end
      for (int j = 0; j < num_pop; j++) begin
        if (last_hold[j]) begin
          assert (pop_valid[j] && pop_data[j] == last_data[j])
            else report($sformatf("pop %0d changed while stalled", j));
        end
        if (pop_valid[j] && pop_ready[j]) begin
          // source id rides in the low data bits
          src = int'(pop_data[j][flow_id_w-1:0]);
          idx = src * num_pop + j;
          assert (src < num_push && sb[idx].size() > 0)
            else report($sformatf("pop %0d got unexpected beat %h", j, pop_data[j]));
          if (src < num_push && sb[idx].size() > 0) begin
            assert (pop_data[j] == sb[idx][0])
              else report($sformatf("pop %0d got %h, expected %h", j, pop_data[j], sb[idx][0]));
            void'(sb[idx].pop_front());
            pending--;
          end
          stall_cnt[j] = 0;
        end else begin
          waiting = 1'b0;
          for (int i = 0; i < num_push; i++)
            waiting |= (sb[i * num_pop + j].size() > 0);
          if (waiting && pop_ready[j])
            stall_cnt[j]++;
        end
        assert (stall_cnt[j] < stall_limit)
          else report($sformatf("pop %0d made no progress for %0d cycles", j, stall_limit));
        last_hold[j] = pop_valid[j] && !pop_ready[j];
        last_data[j] = pop_data[j];
      end
      // every source shows up within num_push transfers on pop 0
      if (!fair_check) begin
        foreach (since_seen[k])
          since_seen[k] = 0;
      end else if (pop_valid[0] && pop_ready[0]) begin
        src = int'(pop_data[0][flow_id_w-1:0]);
        for (int k = 0; k < num_push; k++) begin
          since_seen[k] = (k == src) ? 0 : since_seen[k] + 1;
          assert (since_seen[k] < num_push)
            else report($sformatf("source %0d starved on pop 0", k));
        end
      end
    end
  end

endmodule

// ==== testbench/tb_flow_xbar.sv ====
/* flow crossbar testbench */

`timescale 1ns/1ps

module tb_flow_xbar;

  import flow_cfg_pkg::*;
  import flow_types_pkg::*;

  localparam int num_push = default_num_push;
  localparam int num_pop = default_num_pop;
  localparam int reset_cycles = 10;
  localparam int probe_cycles = 16;
  localparam int sat_cycles = 200;
  localparam int random_cycles = 2000;
  localparam int drain_cycles = 64;
  localparam int max_cycles = reset_cycles + probe_cycles + sat_cycles + drain_cycles
                              + random_cycles + drain_cycles + 200;

  logic                       clk;
  logic                       reset;
  logic [num_push-1:0]        push_valid;
  logic [num_push-1:0]        push_ready;
  flow_beat_t [num_push-1:0]  push_beat;
  logic [num_pop-1:0]         pop_valid;
  logic [num_pop-1:0]         pop_ready;
  flow_data_t [num_pop-1:0]   pop_data;
  logic                       fair_check;
  int                         pending;
  logic                       mon_error;
  logic [31:0]                lfsr_state;
  int                         cycle_count = 0;

  flow_xbar #(
    .num_push              (num_push),
    .num_pop               (num_pop),
    .register_demux_outputs(1'b1),
    .register_pop_outputs  (1'b1)
  ) i_flow_xbar (
    .clk       (clk),
    .reset     (reset),
    .push_valid(push_valid),
    .push_ready(push_ready),
    .push_beat (push_beat),
    .pop_valid (pop_valid),
    .pop_ready (pop_ready),
    .pop_data  (pop_data)
  );

  xbar_monitor #(
    .num_push(num_push),
    .num_pop (num_pop)
  ) i_monitor (
    .clk       (clk),
    .reset     (reset),
    .push_valid(push_valid),
    .push_ready(push_ready),
    .push_beat (push_beat),
    .pop_valid (pop_valid),
    .pop_ready (pop_ready),
    .pop_data  (pop_data),
    .fair_check(fair_check),
    .pending   (pending),
    .error     (mon_error)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("TEST FAILED");
      $fatal(1, "simulation timed out");
    end
  end

  always @(posedge mon_error) begin
    $display("TEST FAILED");
    $fatal(1, "monitor check failed");
  end

  task automatic fail_check(input string msg);
    $display("FAILED t=%0t: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "testbench check failed");
  endtask

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // one clock of traffic; mode 0 adds no beats, 1 saturates pop 0, 2 is random
  task automatic run_cycle(input int mode);
    logic [num_push-1:0] fired;
    logic [31:0]         r;
    @(negedge clk);
    fired = push_valid & push_ready;
    @(posedge clk);
    #1;
    fair_check = (mode == 1);
    for (int i = 0; i < num_push; i++) begin
      if (!push_valid[i] || fired[i]) begin
        take_bits(2, r);
        push_valid[i] = (mode == 1) || (mode == 2 && r[1:0] != 2'd0);
        take_bits($clog2(num_pop), r);
        push_beat[i].dest = (mode == 1) ? '0 : flow_id_t'(r);
        take_bits(flow_data_w - flow_id_w, r);
        push_beat[i].data = {r[flow_data_w-flow_id_w-1:0], flow_id_t'(i)};
      end
    end
    for (int j = 0; j < num_pop; j++) begin
      take_bits(2, r);
      pop_ready[j] = (mode != 2) || (r[1:0] != 2'd0);
    end
  endtask

  // stop new beats and wait for the scoreboard to empty
  task automatic drain();
    int waited;
    waited = 0;
    while ((push_valid != '0 || pending != 0) && waited < drain_cycles) begin
      run_cycle(0);
      waited++;
    end
  endtask

  initial begin
    int lat;
    int waited;
    lfsr_state = 32'hd7555262;
    reset = 1'b1;
    push_valid = '0;
    push_beat = '0;
    pop_ready = '0;
    fair_check = 1'b0;

    repeat (reset_cycles) begin
      @(negedge clk);
      assert (pop_valid == '0) else fail_check("pop_valid high during reset");
    end
    @(posedge clk);
    #1;
    reset = 1'b0;
    pop_ready = '1;
    // first clock edge that sees reset low
    @(posedge clk);
    @(negedge clk);
    assert (pop_valid == '0) else fail_check("pop_valid high after reset");

    // one beat from push 1 to pop 2 on an idle crossbar
    @(posedge clk);
    #1;
    push_valid[1] = 1'b1;
    push_beat[1].data = 16'h5a51;
    push_beat[1].dest = flow_id_t'(2);
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!push_ready[1] && waited < probe_cycles);
    @(posedge clk);
    #1;
    push_valid[1] = 1'b0;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!pop_valid[2] && lat < probe_cycles);
    assert (lat == 2) else fail_check($sformatf("latency %0d cycles, expected 2", lat));

    repeat (sat_cycles)
      run_cycle(1);
    drain();
    repeat (random_cycles)
      run_cycle(2);
    drain();

    if (pending == 0 && push_valid == '0 && !mon_error) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("drain did not finish, %0d beats still expected", pending);
      $display("TEST FAILED");
      $fatal(1, "scoreboard not empty");
    end
  end

endmodule

// ==== list.f ====
src/flow_cfg_pkg.sv
src/flow_types_pkg.sv
src/flow_demux.sv
src/flow_rr_arbiter.sv
src/flow_mux.sv
src/flow_xbar.sv
testbench/xbar_monitor.sv
testbench/tb_flow_xbar.sv

// ==== Bender.yml ====
package:
  name: flow_xbar

sources:
  - files:
      - src/flow_cfg_pkg.sv
      - src/flow_types_pkg.sv
      - src/flow_demux.sv
      - src/flow_rr_arbiter.sv
      - src/flow_mux.sv
      - src/flow_xbar.sv
  - target: test
    files:
      - testbench/xbar_monitor.sv
      - testbench/tb_flow_xbar.sv
